// ==== sine_lut.svh ====
// --------------------------------------
// sine table function
// --------------------------------------

`ifndef SINE_LUT_SVH
`define SINE_LUT_SVH

// one full period over 256 entries, amplitude 127
// each half period uses the rational approximation
//   sin(x) ~ 16 x (pi - x) / (5 pi^2 - 4 x (pi - x))
// with x = pi * i / 128 this reduces to pure integers:
//   127 * 16 p / (81920 - 4 p), p = i * (128 - i)
// peak error is under 1 lsb at this amplitude
function automatic logic signed [7:0] sine_lut(input logic [7:0] idx);
  int p;   // i * (128 - i), 0 .. 4096
  int mag; // magnitude 0 .. 127
  logic signed [7:0] res;

  p   = int'(idx[6:0]) * (128 - int'(idx[6:0]));
  mag = (2032 * p) / (81920 - 4 * p);

  // second half period is the mirror
  if (idx[7]) begin
    res = -8'(mag);
  end else begin
    res = 8'(mag);
  end

  return res;
endfunction

`endif

// ==== keyer_pkg.sv ====
// --------------------------------------
// keyer timing definitions
// --------------------------------------

package keyer_pkg;

  // durations, counted in 1 ms ticks
  typedef logic [9:0] ms_t;

  // element timing as seen by the keyer fsm
  typedef struct packed {
    ms_t dot_ms;      // dot length, also element gap
    ms_t dash_adj_ms; // dash weight on top of 3 dots
    ms_t relay_ms;    // tx enable lead before first element
    ms_t hang_ms;     // break-in hold after last element
  } keyer_cfg_t;

  // power-up timing: 50 ms dot, 10 ms lead, 300 ms hang
  localparam keyer_cfg_t KEY_CFG_DEFAULT = '{
    dot_ms:      10'd50,
    dash_adj_ms: 10'd0,
    relay_ms:    10'd10,
    hang_ms:     10'd300
  };

  // iambic keyer states
  typedef enum logic [2:0] {
    idle,     // receive, tx off
    dot_pre,  // relay lead before a dot
    dot_on,   // dot keyed
    dot_off,  // gap after a dot
    dash_pre, // relay lead before a dash
    dash_on,  // dash keyed
    dash_off, // gap after a dash
    hang      // break-in hold
  } keyer_state_e;

endpackage

// ==== audio_pkg.sv ====
// --------------------------------------
// sidetone audio definitions
// --------------------------------------

package audio_pkg;

  typedef logic [15:0]        phase_t;  // phase accumulator, top 8 bits index the table
  typedef logic [7:0]         volume_t; // unsigned gain
  typedef logic signed [15:0] sample_t; // codec sample

  // tone settings
  typedef struct packed {
    phase_t  phase_step; // phase increment per sample tick
    volume_t volume;
  } tone_cfg_t;

  // full payload of the host config port
  typedef struct packed {
    keyer_pkg::keyer_cfg_t key;  // 40 bits
    tone_cfg_t             tone; // 24 bits
  } sys_cfg_t;

endpackage

// ==== keyer_cfg_regs.sv ====
// --------------------------------------
// host config port
// --------------------------------------

`timescale 1ns/1ps

module keyer_cfg_regs (
  input  logic                  clk,
  input  logic                  rstb,
  input  logic                  cfg_req,  // four-phase request from host
  input  audio_pkg::sys_cfg_t   cfg,      // stable while cfg_req high
  output logic                  cfg_ack,
  output keyer_pkg::keyer_cfg_t key_cfg,  // active keyer timing
  output audio_pkg::tone_cfg_t  tone_cfg  // active tone settings
);

  import keyer_pkg::*;

  logic capture; // first cycle of a request

  assign capture = cfg_req & ~cfg_ack;

  // ack follows req one cycle later, settings load on the same edge
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      cfg_ack  <= 1'b0;
      key_cfg  <= KEY_CFG_DEFAULT;
      tone_cfg <= '0; // silent until host sets tone
    end else begin
      cfg_ack <= cfg_req;
      if (capture) begin
        key_cfg  <= cfg.key;
        tone_cfg <= cfg.tone;
      end
    end
  end

  // --------------------------------------
  // handshake check
  // --------------------------------------
  // host keeps req up until ack has risen
  a_ack_needs_req : assert property (
    @(posedge clk) disable iff (!rstb)
    $rose(cfg_ack) |-> cfg_req
  );

endmodule

// ==== tick_gen.sv ====
// --------------------------------------
// ms and sample tick divider
// --------------------------------------

`timescale 1ns/1ps

module tick_gen #(
  parameter int CLKS_PER_MS     = 48000,
  parameter int CLKS_PER_SAMPLE = 1000
) (
  input  logic clk,
  input  logic rstb,
  output logic ms_tick,     // one clk wide, every CLKS_PER_MS
  output logic sample_tick  // one clk wide, every CLKS_PER_SAMPLE
);

  localparam int MS_W = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;
  localparam int SP_W = (CLKS_PER_SAMPLE > 1) ? $clog2(CLKS_PER_SAMPLE) : 1;

  logic [MS_W-1:0] ms_cnt;
  logic [SP_W-1:0] sp_cnt;
  logic            ms_wrap;
  logic            sp_wrap;

  assign ms_wrap = (ms_cnt == MS_W'(CLKS_PER_MS - 1));
  assign sp_wrap = (sp_cnt == SP_W'(CLKS_PER_SAMPLE - 1));

  // free running, pulse registered on wrap
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      ms_cnt      <= '0;
      sp_cnt      <= '0;
      ms_tick     <= 1'b0;
      sample_tick <= 1'b0;
    end else begin
      ms_tick     <= ms_wrap;
      sample_tick <= sp_wrap;
      ms_cnt      <= ms_wrap ? '0 : ms_cnt + 1'b1;
      sp_cnt      <= sp_wrap ? '0 : sp_cnt + 1'b1;
    end
  end

endmodule

// ==== paddle_debounce.sv ====
// --------------------------------------
// paddle debounce and memory
// --------------------------------------

`timescale 1ns/1ps

module paddle_debounce #(
  parameter int REJECT_MS = 5
) (
  input  logic clk,
  input  logic rstb,
  input  logic ms_tick,
  input  logic dot_n,      // dot contact, low = closed
  input  logic dash_n,     // dash contact, low = closed
  input  logic dot_clear,  // dot element started
  input  logic dash_clear, // dash element started
  output logic dot_held,
  output logic dash_held
);

  localparam int CW = $clog2(REJECT_MS + 1);

  logic [CW-1:0] cnt [2]; // index 0 dot, 1 dash
  logic [1:0]    closed;
  logic [1:0]    clear;
  logic [1:0]    sat;

  assign closed = {~dash_n, ~dot_n};
  assign clear  = {dash_clear, dot_clear};

  // --------------------------------------
  // per-paddle closed-time counters
  // --------------------------------------
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      for (int i = 0; i < 2; i++) begin
        cnt[i] <= '0;
      end
    end else if (ms_tick) begin
      for (int i = 0; i < 2; i++) begin
        if (clear[i]) begin
          cnt[i] <= '0;          // element taken, forget it
        end else if (sat[i]) begin
          cnt[i] <= cnt[i];      // latched until used
        end else if (closed[i]) begin
          cnt[i] <= cnt[i] + 1'b1;
        end else begin
          cnt[i] <= '0;          // bounce, start over
        end
      end
    end
  end

  for (genvar g = 0; g < 2; g++) begin : g_sat
    assign sat[g] = (cnt[g] == CW'(REJECT_MS));
  end

  assign dot_held  = sat[0];
  assign dash_held = sat[1];

endmodule

// ==== keyer_fsm.sv ====
// --------------------------------------
// iambic keyer control
// --------------------------------------

`timescale 1ns/1ps

module keyer_fsm (
  input  logic                  clk,
  input  logic                  rstb,
  input  logic                  ms_tick,
  input  keyer_pkg::keyer_cfg_t key_cfg,
  input  logic                  dot_held,
  input  logic                  dash_held,
  output logic                  dot_clear,  // empties dot memory
  output logic                  dash_clear, // empties dash memory
  output logic                  tx_en,      // relay / pa bias
  output logic                  key_on      // element keyed
);

  import keyer_pkg::*;

  keyer_state_e state;
  keyer_state_e state_nxt;
  ms_t          cnt;       // ticks left in this state, minus one
  ms_t          cnt_nxt;
  ms_t          dash_len;
  logic         cnt_done;

  // dash = 3 dots + weight, wraps past 1023 ms
  assign dash_len = ms_t'(3 * key_cfg.dot_ms + key_cfg.dash_adj_ms);
  assign cnt_done = (cnt == '0);

  // --------------------------------------
  // next state, evaluated on ms ticks only
  // --------------------------------------
  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    if (ms_tick) begin
      if (!cnt_done) begin
        cnt_nxt = cnt - 1'b1;
      end
      case (state)
        idle: begin
          if (dot_held) begin
            state_nxt = dot_pre;
            cnt_nxt   = key_cfg.relay_ms;
          end else if (dash_held) begin
            state_nxt = dash_pre;
            cnt_nxt   = key_cfg.relay_ms;
          end
        end
        dot_pre, dot_off, hang: begin
          if (state == hang && dot_held) begin
            state_nxt = dot_on;    // restart inside hang, no lead
            cnt_nxt   = key_cfg.dot_ms;
          end else if (state == hang && dash_held) begin
            state_nxt = dash_on;
            cnt_nxt   = dash_len;
          end else if (cnt_done) begin
            if (state == hang) begin
              state_nxt = idle;
            end else if (state == dot_pre) begin
              state_nxt = dot_on;
              cnt_nxt   = key_cfg.dot_ms;
            end else if (dash_held) begin
              state_nxt = dash_on; // after a dot, dash wins
              cnt_nxt   = dash_len;
            end else if (dot_held) begin
              state_nxt = dot_on;
              cnt_nxt   = key_cfg.dot_ms;
            end else begin
              state_nxt = hang;
              cnt_nxt   = key_cfg.hang_ms;
            end
          end
        end
        dash_pre, dash_off: begin
          if (cnt_done) begin
            if (state == dash_pre) begin
              state_nxt = dash_on;
              cnt_nxt   = dash_len;
            end else if (dot_held) begin
              state_nxt = dot_on;  // after a dash, dot wins
              cnt_nxt   = key_cfg.dot_ms;
            end else if (dash_held) begin
              state_nxt = dash_on;
              cnt_nxt   = dash_len;
            end else begin
              state_nxt = hang;
              cnt_nxt   = key_cfg.hang_ms;
            end
          end
        end
        dot_on: begin
          if (cnt_done) begin
            state_nxt = dot_off;   // gap is one dot
            cnt_nxt   = key_cfg.dot_ms;
          end
        end
        dash_on: begin
          if (cnt_done) begin
            state_nxt = dash_off;
            cnt_nxt   = key_cfg.dot_ms;
          end
        end
        default: state_nxt = idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      state <= idle;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  // clear on entry into an element, same tick as the transition
  assign dot_clear  = (state_nxt == dot_on) && (state != dot_on);
  assign dash_clear = (state_nxt == dash_on) && (state != dash_on);

  // outputs straight from the state register
  assign tx_en  = (state != idle);
  assign key_on = (state == dot_on) || (state == dash_on);

  // keying without tx enable would hot-switch the relay
  // tx_en already up in the cycle before any keyed cycle
  a_key_in_tx : assert property (
    @(posedge clk) disable iff (!rstb)
    key_on |-> $past(tx_en)
  );

endmodule

// ==== sidetone_gen.sv ====
// --------------------------------------
// sidetone generator
// --------------------------------------

`timescale 1ns/1ps

module sidetone_gen (
  input  logic                 clk,
  input  logic                 rstb,
  input  logic                 sample_tick,
  input  logic                 key_on,
  input  audio_pkg::tone_cfg_t tone_cfg,
  output audio_pkg::sample_t   sample,      // to codec
  output logic                 sidetone_sq  // piezo drive, low when silent
);

  import audio_pkg::*;

  `include "sine_lut.svh"

  logic signed [7:0]  rom [256];   // elaborated from sine_lut
  phase_t             phase;
  logic               tick_d;      // sample slot, one clk after the tick
  logic               tone_on;
  logic               tone_on_nxt;
  logic               last_sign;   // sign at previous sample
  logic signed [7:0]  lut_val;
  logic               zero_cross;
  logic signed [16:0] prod;

  for (genvar g = 0; g < 256; g++) begin : g_rom
    assign rom[g] = sine_lut(8'(g));
  end

  assign lut_val     = rom[phase[15:8]];
  assign zero_cross  = (lut_val[7] != last_sign);
  assign tone_on_nxt = key_on | (tone_on & ~zero_cross); // hold to the next crossing
  assign prod        = lut_val * $signed({1'b0, tone_cfg.volume}); // fits in 16 bits

  // --------------------------------------
  // phase at the tick, sample one clk later
  // --------------------------------------
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      tick_d      <= 1'b0;
      phase       <= '0;
      tone_on     <= 1'b0;
      last_sign   <= 1'b0;
      sample      <= '0;
      sidetone_sq <= 1'b0;
    end else begin
      tick_d <= sample_tick;
      if (sample_tick) begin
        phase <= tone_on ? phase + tone_cfg.phase_step : '0; // restart at zero phase
      end
      if (tick_d) begin
        tone_on     <= tone_on_nxt;
        last_sign   <= lut_val[7];
        sample      <= tone_on_nxt ? sample_t'(prod[15:0]) : '0;
        sidetone_sq <= tone_on_nxt & ~lut_val[7]; // high on positive half
      end
    end
  end

  // piezo and codec sit in the same half period
  a_sq_sign : assert property (
    @(posedge clk) disable iff (!rstb)
    sidetone_sq |-> !sample[15]
  );

endmodule

// ==== keyer_top.sv ====
// --------------------------------------
// iambic keyer top
// --------------------------------------

`timescale 1ns/1ps

module keyer_top #(
  parameter int CLKS_PER_MS     = 48000,
  parameter int CLKS_PER_SAMPLE = 1000,
  parameter int REJECT_MS       = 5
) (
  input  logic                clk,
  input  logic                rstb,
  input  logic                dot_n,       // paddle contacts, active low
  input  logic                dash_n,
  input  logic                cfg_req,
  input  audio_pkg::sys_cfg_t cfg,
  output logic                cfg_ack,
  output logic                tx_en,
  output logic                key_on,
  output audio_pkg::sample_t  sample,
  output logic                sidetone_sq
);

  import keyer_pkg::*;
  import audio_pkg::*;

  keyer_cfg_t key_cfg;
  tone_cfg_t  tone_cfg;
  logic       ms_tick;
  logic       sample_tick;
  logic       dot_held;
  logic       dash_held;
  logic       dot_clear;
  logic       dash_clear;

  keyer_cfg_regs keyer_cfg_regs_inst (
    .clk      (clk),
    .rstb     (rstb),
    .cfg_req  (cfg_req),
    .cfg      (cfg),
    .cfg_ack  (cfg_ack),
    .key_cfg  (key_cfg),
    .tone_cfg (tone_cfg)
  );

  tick_gen #(
    .CLKS_PER_MS     (CLKS_PER_MS),
    .CLKS_PER_SAMPLE (CLKS_PER_SAMPLE)
  ) tick_gen_inst (
    .clk         (clk),
    .rstb        (rstb),
    .ms_tick     (ms_tick),
    .sample_tick (sample_tick)
  );

  paddle_debounce #(
    .REJECT_MS (REJECT_MS)
  ) paddle_debounce_inst (
    .clk        (clk),
    .rstb       (rstb),
    .ms_tick    (ms_tick),
    .dot_n      (dot_n),
    .dash_n     (dash_n),
    .dot_clear  (dot_clear),
    .dash_clear (dash_clear),
    .dot_held   (dot_held),
    .dash_held  (dash_held)
  );

  keyer_fsm keyer_fsm_inst (
    .clk        (clk),
    .rstb       (rstb),
    .ms_tick    (ms_tick),
    .key_cfg    (key_cfg),
    .dot_held   (dot_held),
    .dash_held  (dash_held),
    .dot_clear  (dot_clear),
    .dash_clear (dash_clear),
    .tx_en      (tx_en),
    .key_on     (key_on)
  );

  // tone runs while keyed, then to the next zero crossing
  sidetone_gen sidetone_gen_inst (
    .clk         (clk),
    .rstb        (rstb),
    .sample_tick (sample_tick),
    .key_on      (key_on),
    .tone_cfg    (tone_cfg),
    .sample      (sample),
    .sidetone_sq (sidetone_sq)
  );

endmodule

// ==== tb_keyer_model.svh ====
// --------------------------------------
// keyer reference model
// --------------------------------------

`ifndef TB_KEYER_MODEL_SVH
`define TB_KEYER_MODEL_SVH

int           m_ms_cnt;
int           m_sp_cnt;
logic         m_ms_tick;
logic         m_sp_tick;
logic         m_ack;
keyer_cfg_t   m_key;
tone_cfg_t    m_tone;
int           m_db [2];     // closed-tick count, 0 dot, 1 dash
keyer_state_e m_state;
ms_t          m_tcnt;
logic         m_tick_d;
phase_t       m_phase;
logic         m_tone_on;
logic         m_last_sign;
sample_t      m_sample;
logic         m_sq;

// sine of idx * 2 pi / 256, amplitude 127, rational approximation per half period
function automatic int sine_ref(input int idx);
  int k;
  int p;
  int m;
  k = idx % 128;
  p = k * (128 - k);
  m = (2032 * p) / (81920 - 4 * p);
  return (idx >= 128) ? -m : m;
endfunction

task automatic model_reset();
  m_ms_cnt    = 0;
  m_sp_cnt    = 0;
  m_ms_tick   = 0;
  m_sp_tick   = 0;
  m_ack       = 0;
  m_key       = '{dot_ms: 10'd50, dash_adj_ms: 10'd0, relay_ms: 10'd10, hang_ms: 10'd300};
  m_tone      = '0;
  m_db[0]     = 0;
  m_db[1]     = 0;
  m_state     = idle;
  m_tcnt      = '0;
  m_tick_d    = 0;
  m_phase     = '0;
  m_tone_on   = 0;
  m_last_sign = 0;
  m_sample    = '0;
  m_sq        = 0;
endtask

// one clk edge, all next values from the current ones
task automatic model_step(input logic dot_n_i, input logic dash_n_i, input logic req_i,
                          input sys_cfg_t cfg_i);
  keyer_state_e st_n;
  ms_t          tc_n;
  ms_t          dash_len;
  logic         held [2];
  logic         clr [2];
  logic         closed [2];
  logic         key_now;
  logic         on_n;
  int           val;
  held[0]  = (m_db[0] == REJECT_MS);
  held[1]  = (m_db[1] == REJECT_MS);
  closed[0] = !dot_n_i;
  closed[1] = !dash_n_i;
  dash_len = ms_t'(3 * m_key.dot_ms + m_key.dash_adj_ms);
  key_now  = (m_state == dot_on) || (m_state == dash_on);
  st_n     = m_state;
  tc_n     = m_tcnt;

  // element sequencing, one step per ms tick
  if (m_ms_tick) begin
    if (m_tcnt != 0) tc_n = m_tcnt - 1'b1;
    case (m_state)
      idle: begin
        if (held[0]) begin
          st_n = dot_pre;
          tc_n = m_key.relay_ms;
        end else if (held[1]) begin
          st_n = dash_pre;
          tc_n = m_key.relay_ms;
        end
      end
      dot_pre: if (m_tcnt == 0) begin
        st_n = dot_on;
        tc_n = m_key.dot_ms;
      end
      dash_pre: if (m_tcnt == 0) begin
        st_n = dash_on;
        tc_n = dash_len;
      end
      dot_on: if (m_tcnt == 0) begin
        st_n = dot_off;
        tc_n = m_key.dot_ms;
      end
      dash_on: if (m_tcnt == 0) begin
        st_n = dash_off;
        tc_n = m_key.dot_ms;
      end
      dot_off, dash_off: begin
        if (m_tcnt == 0) begin
          // the opposite paddle has priority at the end of a gap
          if (m_state == dot_off ? held[1] : !held[0] && held[1]) begin
            st_n = dash_on;
            tc_n = dash_len;
          end else if (held[0]) begin
            st_n = dot_on;
            tc_n = m_key.dot_ms;
          end else begin
            st_n = hang;
            tc_n = m_key.hang_ms;
          end
        end
      end
      hang: begin
        if (held[0]) begin
          st_n = dot_on;            // no new lead inside hang
          tc_n = m_key.dot_ms;
        end else if (held[1]) begin
          st_n = dash_on;
          tc_n = dash_len;
        end else if (m_tcnt == 0) begin
          st_n = idle;
        end
      end
      default: st_n = idle;
    endcase
  end
  clr[0] = (st_n == dot_on) && (m_state != dot_on);
  clr[1] = (st_n == dash_on) && (m_state != dash_on);

  // debounce counters
  if (m_ms_tick) begin
    for (int i = 0; i < 2; i++) begin
      if (clr[i]) m_db[i] = 0;
      else if (held[i]) m_db[i] = m_db[i];
      else if (closed[i]) m_db[i] = m_db[i] + 1;
      else m_db[i] = 0;
    end
  end

  // sidetone, sample registered one clk after the tick
  if (m_tick_d) begin
    val         = sine_ref(int'(m_phase[15:8]));
    on_n        = key_now || (m_tone_on && ((val < 0) == m_last_sign));
    m_sample    = on_n ? sample_t'(val * int'(m_tone.volume)) : '0;
    m_sq        = on_n && (val > 0 || val == 0);
    m_tone_on   = on_n;
    m_last_sign = (val < 0);
  end
  m_tick_d = m_sp_tick;
  if (m_sp_tick) begin
    m_phase = m_tone_on ? phase_t'(m_phase + m_tone.phase_step) : '0;
  end

  // config port
  if (req_i && !m_ack) begin
    m_key  = cfg_i.key;
    m_tone = cfg_i.tone;
  end
  m_ack = req_i;

  m_state   = st_n;
  m_tcnt    = tc_n;
  m_ms_tick = (m_ms_cnt == CLKS_PER_MS - 1);
  m_sp_tick = (m_sp_cnt == CLKS_PER_SAMPLE - 1);
  m_ms_cnt  = m_ms_tick ? 0 : m_ms_cnt + 1;
  m_sp_cnt  = m_sp_tick ? 0 : m_sp_cnt + 1;
endtask

`endif

// ==== tb_keyer.sv ====
// --------------------------------------
// iambic keyer testbench
// --------------------------------------

`timescale 1ns/1ps

module tb_keyer;

  import keyer_pkg::*;
  import audio_pkg::*;

  localparam int CLKS_PER_MS     = 8;
  localparam int CLKS_PER_SAMPLE = 4;
  localparam int REJECT_MS       = 5;
  localparam int NUM_SCEN        = 24;
  localparam int SCEN_MS         = 250; // two long holds plus drain, worst case
  localparam int MAX_CYCLES      = NUM_SCEN * (SCEN_MS * CLKS_PER_MS + 32) + 64;

  logic       clk;
  logic       rstb;
  logic       dot_n;
  logic       dash_n;
  logic       cfg_req;
  sys_cfg_t   cfg;
  logic       cfg_ack;
  logic       tx_en;
  logic       key_on;
  sample_t    sample;
  logic       sidetone_sq;
  logic [31:0] lfsr;
  int         cycles;
  int         errors;

  `include "tb_keyer_model.svh"

  keyer_top #(
    .CLKS_PER_MS     (CLKS_PER_MS),
    .CLKS_PER_SAMPLE (CLKS_PER_SAMPLE),
    .REJECT_MS       (REJECT_MS)
  ) keyer_top_inst (
    .clk         (clk),
    .rstb        (rstb),
    .dot_n       (dot_n),
    .dash_n      (dash_n),
    .cfg_req     (cfg_req),
    .cfg         (cfg),
    .cfg_ack     (cfg_ack),
    .tx_en       (tx_en),
    .key_on      (key_on),
    .sample      (sample),
    .sidetone_sq (sidetone_sq)
  );

  always #20 clk = ~clk; // 40 ns period

  // --------------------------------------
  // helpers
  // --------------------------------------
  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // model steps on every edge, with inputs as they were before it
  always @(posedge clk) begin
    if (!rstb) model_reset();
    else model_step(dot_n, dash_n, cfg_req, cfg);
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // outputs are stable mid-cycle
  always @(negedge clk) begin
    check("cfg_ack", 32'(cfg_ack), 32'(m_ack));
    check("tx_en", 32'(tx_en), 32'(m_state != idle));
    check("key_on", 32'(key_on), 32'((m_state == dot_on) || (m_state == dash_on)));
    check("sample", 32'(sample), 32'(m_sample));
    check("sidetone_sq", 32'(sidetone_sq), 32'(m_sq));
  end

  // four-phase write, ack edges one clk after req edges
  task automatic write_cfg(input sys_cfg_t v);
    @(posedge clk);
    cfg_req <= 1'b1;
    cfg     <= v;
    @(posedge clk);
    @(negedge clk);
    check("cfg_ack rise", 32'(cfg_ack), 32'd1);
    @(posedge clk);
    cfg_req <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check("cfg_ack fall", 32'(cfg_ack), 32'd0);
  endtask

  task automatic hold_paddles(input logic dot, input logic dash, input int ms);
    @(posedge clk);
    dot_n  <= ~dot;
    dash_n <= ~dash;
    repeat (ms * CLKS_PER_MS) @(posedge clk);
  endtask

  // release and wait for silence, bounded by the cycle limit
  task automatic settle();
    @(posedge clk);
    dot_n  <= 1'b1;
    dash_n <= 1'b1;
    do @(negedge clk);
    while (m_state != idle || m_tone_on || m_db[0] != 0 || m_db[1] != 0);
  endtask

  task automatic random_cfg(input logic long_hang);
    sys_cfg_t v;
    v.key.dot_ms          = 10'(1 + rand_bits(2));
    v.key.dash_adj_ms     = 10'(rand_bits(2));
    v.key.relay_ms        = 10'(rand_bits(2));
    v.key.hang_ms         = 10'(rand_bits(3) + (long_hang ? REJECT_MS + 1 : 0));
    v.tone.phase_step     = 16'h0800 + 16'(rand_bits(13)); // crossing within 16 samples
    v.tone.volume         = volume_t'(rand_bits(8));
    write_cfg(v);
  endtask

  // --------------------------------------
  // scenarios
  // --------------------------------------
  initial begin
    int mode;
    clk     = 1'b0;
    rstb    = 1'b0;
    dot_n   = 1'b1;
    dash_n  = 1'b1;
    cfg_req = 1'b0;
    cfg     = '0;
    lfsr    = 32'h3c614588;
    cycles  = 0;
    errors  = 0;
    model_reset();
    repeat (4) @(posedge clk);
    rstb <= 1'b1;
    repeat (2) @(posedge clk);

    for (int s = 0; s < NUM_SCEN; s++) begin
      mode = (s < 5) ? s : int'(rand_bits(3)) % 5;
      random_cfg(mode == 4); // hang outlasts the debounce of a press made in it
      case (mode)
        0: hold_paddles(1'b1, 1'b0, REJECT_MS + 1 + int'(rand_bits(2))); // dot tap
        1: hold_paddles(1'b0, 1'b1, REJECT_MS + 1 + int'(rand_bits(2))); // dash tap
        2: hold_paddles(1'b1, 1'b1, REJECT_MS + 1 + int'(rand_bits(5))); // squeeze
        3: begin
          // too short to pass the debounce
          // at most REJECT_MS - 1 ticks see it closed
          @(posedge clk);
          dot_n <= 1'b0;
          repeat ((REJECT_MS - 1) * CLKS_PER_MS - 2) @(posedge clk);
          dot_n <= 1'b1;
          repeat ((REJECT_MS + 2) * CLKS_PER_MS) begin
            @(negedge clk);
            check("tx_en short tap", 32'(tx_en), 32'd0);
          end
        end
        default: begin
          // second press lands in the hang
          hold_paddles(1'b1, 1'b0, REJECT_MS + 1);
          @(posedge clk);
          dot_n <= 1'b1;
          while (m_state != hang) @(negedge clk);
          hold_paddles(1'b0, 1'b1, REJECT_MS + 1 + int'(rand_bits(3)));
        end
      endcase
      settle();
    end

    if (errors == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== filelist.f ====
+incdir+.
keyer_pkg.sv
audio_pkg.sv
keyer_cfg_regs.sv
tick_gen.sv
paddle_debounce.sv
keyer_fsm.sv
sidetone_gen.sv
keyer_top.sv
tb_keyer.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_keyer -f filelist.f -o vsim
	./obj_dir/vsim | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
